//--- files.f
rtl/mips_pkg.sv
rtl/reg_file.sv
rtl/fetch_stage.sv
rtl/hazard_unit.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/writeback_stage.sv
rtl/mips_core.sv
tb/mips_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mips_core_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/mips_core_tb.sv
// every program ends in an illegal word; the core is reset before each program so registers start at 0
`timescale 1ns/10ps
module mips_core_tb
    import mips_pkg::*;
();
    localparam int    TIMEOUT_CYCLES = 200;
    localparam int    PROG_WORDS     = 16;
    localparam int    MAX_CHECKS     = 8;
    localparam word_t ILLEGAL_WORD   = 32'hFFFF_FFFF; // opcode 0x3f is not decoded

    typedef struct packed {
        word_t [PROG_WORDS-1:0]     words;
        logic [3:0]                 n_chk;
        reg_addr_t [MAX_CHECKS-1:0] chk_addr;
        word_t [MAX_CHECKS-1:0]     chk_val;
        exc_cause_t                 cause;
        pc_t                        epc;
    } prog_row_t;

    logic               SYS_clk = 1'b0;
    logic               SYS_reset;
    logic               load;
    logic               prog_we;
    logic [IMEM_AW-1:0] prog_addr;
    word_t              prog_data;
    reg_addr_t          dbg_addr;
    word_t              dbg_data;
    logic               halted;
    exc_cause_t         exc_cause;
    pc_t                epc;

    prog_row_t rows[$];
    prog_row_t row; // row under construction

    mips_core mips_core_i (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .load      (load),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .dbg_addr  (dbg_addr),
        .dbg_data  (dbg_data),
        .halted    (halted),
        .exc_cause (exc_cause),
        .epc       (epc)
    );

    always #2 SYS_clk = ~SYS_clk; // 4 ns period

    function automatic word_t rtype_word(input logic [5:0] fn, input int rd, input int rs,
                                         input int rt);
        return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic word_t itype_word(input logic [5:0] op, input int rt, input int rs,
                                         input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            fail_run($sformatf("** Error at %0t ns: %s = 0x%08h, expected 0x%08h",
                               $time, name, got, exp));
    endtask

    task automatic check_cause(input string name, input exc_cause_t got, input exc_cause_t exp);
        if (got !== exp)
            fail_run($sformatf("** Error at %0t ns: %s = %0d, expected %0d",
                               $time, name, got, exp));
    endtask

    task automatic new_row();
        row = '0;
        for (int i = 0; i < PROG_WORDS; i++)
            row.words[i] = ILLEGAL_WORD; // unused slots halt as well
    endtask

    task automatic expect_reg(input int addr, input word_t value);
        row.chk_addr[row.n_chk] = addr[4:0];
        row.chk_val[row.n_chk]  = value;
        row.n_chk               = row.n_chk + 4'd1;
    endtask

    task automatic finish_row(input exc_cause_t cause, input int pc);
        row.cause = cause;
        row.epc   = pc;
        rows.push_back(row);
    endtask

    task automatic build_table();
        // dependent alu chain, ends on the illegal word at 32
        new_row();
        row.words[0] = itype_word(OP_ADDI, 1, 0, 5);
        row.words[1] = itype_word(OP_ADDI, 2, 1, 7);
        row.words[2] = rtype_word(FN_SUB, 3, 2, 1);
        row.words[3] = rtype_word(FN_AND, 4, 3, 2);
        row.words[4] = rtype_word(FN_OR, 5, 4, 1);
        row.words[5] = itype_word(OP_ADDI, 8, 0, -3);
        row.words[6] = rtype_word(FN_SLT, 6, 8, 5);
        row.words[7] = rtype_word(FN_ADD, 7, 6, 3);
        expect_reg(1, 32'd5);
        expect_reg(2, 32'd12);          // 5 + 7
        expect_reg(3, 32'd7);           // 12 - 5
        expect_reg(4, 32'd4);           // 7 & 12
        expect_reg(5, 32'd5);           // 4 | 5
        expect_reg(6, 32'd1);           // -3 < 5
        expect_reg(7, 32'd8);           // 1 + 7
        expect_reg(8, 32'hFFFF_FFFD);
        finish_row(CAUSE_ILLEGAL, 32);

        // store, load back and use the loaded value at once
        new_row();
        row.words[0] = itype_word(OP_ADDI, 1, 0, 40);
        row.words[1] = itype_word(OP_ADDI, 2, 0, 100);
        row.words[2] = itype_word(OP_SW, 2, 1, 8);
        row.words[3] = itype_word(OP_LW, 3, 1, 8);
        row.words[4] = rtype_word(FN_ADD, 4, 3, 1);
        expect_reg(1, 32'd40);
        expect_reg(2, 32'd100);
        expect_reg(3, 32'd100);
        expect_reg(4, 32'd140);         // loaded 100 plus 40
        finish_row(CAUSE_ILLEGAL, 20);

        // taken beq, not taken bne, taken bne
        new_row();
        row.words[0] = itype_word(OP_ADDI, 1, 0, 4);
        row.words[1] = itype_word(OP_ADDI, 2, 0, 4);
        row.words[2] = itype_word(OP_BEQ, 2, 1, 1);
        row.words[3] = itype_word(OP_ADDI, 3, 0, 9);  // skipped
        row.words[4] = itype_word(OP_BNE, 2, 1, 1);
        row.words[5] = itype_word(OP_ADDI, 4, 0, 11);
        row.words[6] = itype_word(OP_BNE, 0, 1, 1);
        row.words[7] = itype_word(OP_ADDI, 6, 0, 6);  // skipped
        row.words[8] = itype_word(OP_ADDI, 7, 0, 2);
        expect_reg(3, 32'd0);
        expect_reg(4, 32'd11);
        expect_reg(6, 32'd0);
        expect_reg(7, 32'd2);
        finish_row(CAUSE_ILLEGAL, 36);

        // 16 doublings of 0x4000 reach 2^30, the next add overflows
        new_row();
        row.words[0] = itype_word(OP_ADDI, 1, 0, 16'h4000);
        row.words[1] = itype_word(OP_ADDI, 8, 0, 16);
        row.words[2] = rtype_word(FN_ADD, 1, 1, 1);
        row.words[3] = itype_word(OP_ADDI, 7, 7, 1);
        row.words[4] = itype_word(OP_BNE, 8, 7, -3);  // back to word 2
        row.words[5] = rtype_word(FN_ADD, 1, 1, 1);
        row.words[6] = itype_word(OP_ADDI, 9, 0, 7);
        expect_reg(1, 32'h4000_0000);
        expect_reg(7, 32'd16);
        expect_reg(9, 32'd0);
        finish_row(CAUSE_OVERFLOW, 20);

        // lw from byte address 2
        new_row();
        row.words[0] = itype_word(OP_ADDI, 1, 0, 2);
        row.words[1] = itype_word(OP_LW, 2, 1, 0);
        row.words[2] = itype_word(OP_ADDI, 3, 0, 9);
        expect_reg(1, 32'd2);
        expect_reg(2, 32'd0);
        expect_reg(3, 32'd0);
        finish_row(CAUSE_MISALIGN, 4);

        // addi into register zero
        new_row();
        row.words[0] = itype_word(OP_ADDI, 1, 0, 3);
        row.words[1] = itype_word(OP_ADDI, 0, 0, 5);
        row.words[2] = itype_word(OP_ADDI, 2, 0, 6);
        expect_reg(0, 32'd0);
        expect_reg(1, 32'd3);
        expect_reg(2, 32'd0);
        finish_row(CAUSE_ZERO_WRITE, 4);
    endtask

    task automatic apply_reset();
        @(posedge SYS_clk);
        #1;
        SYS_reset = 1'b1;
        repeat (4) @(posedge SYS_clk);
        #1;
        SYS_reset = 1'b0;
        if (halted)
            fail_run("halted is high after reset");
    endtask

    task automatic load_program(input prog_row_t r);
        @(posedge SYS_clk);
        #1;
        load = 1'b1;
        for (int i = 0; i < PROG_WORDS; i++)
        begin
            @(posedge SYS_clk);
            #1;
            prog_we   = 1'b1;
            prog_addr = i[IMEM_AW-1:0];
            prog_data = r.words[i];
        end
        @(posedge SYS_clk);
        #1;
        prog_we = 1'b0; // load stays high through the reset that follows
        @(posedge SYS_clk);
        #1;
        if (halted)
            fail_run("halted is high while the program is loaded");
    endtask

    task automatic wait_halted(input int idx);
        int cycles;
        cycles = 0;
        while (!halted)
        begin
            if (cycles >= TIMEOUT_CYCLES)
                fail_run($sformatf("program %0d did not halt within %0d cycles",
                                   idx, TIMEOUT_CYCLES));
            @(posedge SYS_clk);
            #1;
            cycles++;
        end
    endtask

    task automatic run_program(input prog_row_t r, input int idx);
        $display("running program %0d", idx);
        load_program(r);
        apply_reset(); // clears the registers while load holds the core
        load = 1'b0;
        wait_halted(idx);
        check_cause("exc_cause", exc_cause, r.cause);
        check_word("epc", epc, r.epc);
        for (int k = 0; k < int'(r.n_chk); k++)
        begin
            @(posedge SYS_clk);
            #1;
            dbg_addr = r.chk_addr[k];
            #1; // combinational read settles
            check_word($sformatf("dbg_data (r%0d)", r.chk_addr[k]), dbg_data, r.chk_val[k]);
        end
    endtask

    initial
    begin
        SYS_reset = 1'b1;
        load      = 1'b1; // core held idle until a program is in
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        dbg_addr  = '0;
        build_table();
        apply_reset();
        foreach (rows[i])
            run_program(rows[i], i);
        apply_reset(); // reset must also clear the halt of the last program
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- rtl/mips_core.sv
// five-stage core; hold load high to write the program, then drop it to run until halted
`timescale 1ns/10ps
module mips_core
    import mips_pkg::*;
(
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  logic               load,
    input  logic               prog_we,
    input  logic [IMEM_AW-1:0] prog_addr,
    input  word_t              prog_data,
    input  reg_addr_t          dbg_addr,
    output word_t              dbg_data,
    output logic               halted,
    output exc_cause_t         exc_cause,
    output pc_t                epc
);
    word_t      if_instr;
    pc_t        if_pc;
    logic       if_valid;
    logic       stall;
    logic       fwd_rs;
    logic       fwd_rt;
    logic       branch_taken;
    pc_t        branch_target;
    logic       flush;
    word_t      dec_instr;
    id_ex_t     id_ex;
    id_ex_t     ex_item;
    ex_mem_t    ex_mem;
    mem_wb_t    mem_wb;
    reg_addr_t  mem_dest;
    logic       mem_reg_write;
    word_t      mem_fwd_data;
    reg_write_t wr;

    fetch_stage fetch_stage_i (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .load          (load),
        .prog_we       (prog_we),
        .prog_addr     (prog_addr),
        .prog_data     (prog_data),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .flush         (flush),
        .if_instr      (if_instr),
        .if_pc         (if_pc),
        .if_valid      (if_valid)
    );

    hazard_unit hazard_unit_i (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .dec_instr     (dec_instr),
        .ex_item       (ex_item),
        .mem_dest      (mem_dest),
        .mem_reg_write (mem_reg_write),
        .stall         (stall),
        .fwd_rs        (fwd_rs),
        .fwd_rt        (fwd_rt)
    );

    decode_stage decode_stage_i (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .if_instr      (if_instr),
        .if_pc         (if_pc),
        .if_valid      (if_valid),
        .stall         (stall),
        .flush         (flush),
        .fwd_rs        (fwd_rs),
        .fwd_rt        (fwd_rt),
        .mem_fwd_data  (mem_fwd_data),
        .wr            (wr),
        .dbg_addr      (dbg_addr),
        .dec_instr     (dec_instr),
        .id_ex         (id_ex),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .dbg_data      (dbg_data)
    );

    execute_stage execute_stage_i (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .id_ex     (id_ex),
        .stall     (stall),
        .flush     (flush),
        .ex_mem    (ex_mem),
        .ex_item   (ex_item)
    );

    memory_stage memory_stage_i (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .ex_mem        (ex_mem),
        .flush         (flush),
        .mem_wb        (mem_wb),
        .mem_dest      (mem_dest),
        .mem_reg_write (mem_reg_write),
        .mem_fwd_data  (mem_fwd_data)
    );

    writeback_stage writeback_stage_i (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .load      (load),
        .mem_wb    (mem_wb),
        .wr        (wr),
        .flush     (flush),
        .halted    (halted),
        .exc_cause (exc_cause),
        .epc       (epc)
    );

endmodule

//--- rtl/writeback_stage.sv
// the first excepting instruction halts the core until reset or load; it is never written
`timescale 1ns/10ps
module writeback_stage
    import mips_pkg::*;
(
    input  logic       SYS_clk,
    input  logic       SYS_reset,
    input  logic       load,
    input  mem_wb_t    mem_wb,
    output reg_write_t wr,
    output logic       flush,
    output logic       halted,
    output exc_cause_t exc_cause,
    output pc_t        epc
);
    logic       zero_write;
    exc_cause_t cause;
    logic       exc_now;

    assign zero_write = mem_wb.ctrl.reg_write && (mem_wb.dest == 5'd0);
    assign cause      = (mem_wb.cause != CAUSE_NONE) ? mem_wb.cause
                      : zero_write ? CAUSE_ZERO_WRITE : CAUSE_NONE;
    assign exc_now    = mem_wb.valid && (cause != CAUSE_NONE);

    assign flush = exc_now || halted; // squashes everything younger

    assign wr.en   = mem_wb.valid && mem_wb.ctrl.reg_write && !flush;
    assign wr.addr = mem_wb.dest;
    assign wr.data = mem_wb.ctrl.mem_to_reg ? mem_wb.read_data : mem_wb.alu_result;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            halted    <= 1'b0;
            exc_cause <= CAUSE_NONE;
            epc       <= '0;
        end
        else if (load)
        begin
            halted    <= 1'b0;
            exc_cause <= CAUSE_NONE;
            epc       <= '0;
        end
        else if (exc_now && !halted)
        begin
            halted    <= 1'b1;
            exc_cause <= cause;
            epc       <= mem_wb.pc; // address of the excepting word
        end
    end

endmodule

//--- rtl/memory_stage.sv
// data memory wraps past 64 words; a load forwards its read data, other writers their alu result
`timescale 1ns/10ps
module memory_stage
    import mips_pkg::*;
(
    input  logic      SYS_clk,
    input  logic      SYS_reset,
    input  ex_mem_t   ex_mem,
    input  logic      flush,
    output mem_wb_t   mem_wb,
    output reg_addr_t mem_dest,
    output logic      mem_reg_write,
    output word_t     mem_fwd_data
);
    word_t              dmem [DMEM_DEPTH];
    logic [DMEM_AW-1:0] word_addr;
    logic               misalign;
    exc_cause_t         cause;
    ctrl_t              ctrl;
    word_t              read_data;
    logic               dmem_we;

    assign word_addr = ex_mem.alu_result[DMEM_AW+1:2];
    assign misalign  = ex_mem.valid && (ex_mem.ctrl.mem_read || ex_mem.ctrl.mem_write)
                    && (ex_mem.alu_result[1:0] != 2'b00);

    assign cause = (ex_mem.cause != CAUSE_NONE) ? ex_mem.cause
                 : misalign ? CAUSE_MISALIGN : CAUSE_NONE;
    assign ctrl  = (cause != CAUSE_NONE) ? '0 : ex_mem.ctrl; // no access once caused

    assign read_data = dmem[word_addr];
    assign dmem_we   = ex_mem.valid && ctrl.mem_write && !flush;

    always_ff @(posedge SYS_clk)
    begin
        if (dmem_we)
            dmem[word_addr] <= ex_mem.store_data;
    end

    assign mem_dest      = ex_mem.dest;
    assign mem_reg_write = ex_mem.valid && ctrl.reg_write;
    assign mem_fwd_data  = ctrl.mem_to_reg ? read_data : ex_mem.alu_result;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            mem_wb <= '0;
        else if (flush)
            mem_wb <= '0;
        else
        begin
            mem_wb.valid      <= ex_mem.valid;
            mem_wb.pc         <= ex_mem.pc;
            mem_wb.ctrl       <= ctrl;
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.read_data  <= read_data;
            mem_wb.dest       <= ex_mem.dest;
            mem_wb.cause      <= cause;
        end
    end

    // once flush is up the execute stage stops sending work, so no store can follow
    no_store_after_flush : assert property (
        @(posedge SYS_clk) disable iff (SYS_reset) flush |=> !ex_mem.valid);

endmodule

//--- rtl/execute_stage.sv
// signed overflow is checked on add, sub and addi only; address arithmetic for lw and sw wraps
`timescale 1ns/10ps
module execute_stage
    import mips_pkg::*;
(
    input  logic    SYS_clk,
    input  logic    SYS_reset,
    input  id_ex_t  id_ex,
    input  logic    stall,
    input  logic    flush,
    output ex_mem_t ex_mem,
    output id_ex_t  ex_item
);
    word_t      op_b;
    word_t      result;
    logic       overflow;
    exc_cause_t cause;

    assign op_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : id_ex.rt_val;

    always_comb
    begin
        result   = '0;
        overflow = 1'b0;
        case (id_ex.ctrl.alu_op)
            ALU_ADD:
            begin
                result   = id_ex.rs_val + op_b;
                overflow = (id_ex.rs_val[31] == op_b[31]) && (result[31] != op_b[31]);
            end
            ALU_SUB:
            begin
                result   = id_ex.rs_val - op_b;
                overflow = (id_ex.rs_val[31] != op_b[31]) && (result[31] != id_ex.rs_val[31]);
            end
            ALU_AND: result = id_ex.rs_val & op_b;
            ALU_OR:  result = id_ex.rs_val | op_b;
            ALU_SLT: result = {31'b0, $signed(id_ex.rs_val) < $signed(op_b)};
            default: result = '0;
        endcase
        if (id_ex.ctrl.mem_read || id_ex.ctrl.mem_write)
            overflow = 1'b0;
    end

    assign cause = (id_ex.cause != CAUSE_NONE) ? id_ex.cause      // older cause wins
                 : (id_ex.valid && overflow)   ? CAUSE_OVERFLOW
                 : CAUSE_NONE;

    always_comb
    begin
        ex_item       = id_ex;
        ex_item.cause = cause;
        if (cause != CAUSE_NONE)
            ex_item.ctrl = '0;
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            ex_mem <= '0;
        else if (flush)
            ex_mem <= '0;
        else
        begin
            ex_mem.valid      <= ex_item.valid;
            ex_mem.pc         <= ex_item.pc;
            ex_mem.ctrl       <= ex_item.ctrl;
            ex_mem.alu_result <= result;
            ex_mem.store_data <= ex_item.rt_val;
            ex_mem.dest       <= ex_item.dest;
            ex_mem.cause      <= ex_item.cause;
        end
    end

    // the word held in decode during a stall must not arrive here twice
    stall_sends_bubble : assert property (
        @(posedge SYS_clk) disable iff (SYS_reset)
        stall |=> !id_ex.valid);

endmodule

//--- rtl/decode_stage.sv
// branches resolve here with forwarded operands; unknown encodings leave as illegal with no control
`timescale 1ns/10ps
module decode_stage
    import mips_pkg::*;
(
    input  logic       SYS_clk,
    input  logic       SYS_reset,
    input  word_t      if_instr,
    input  pc_t        if_pc,
    input  logic       if_valid,
    input  logic       stall,
    input  logic       flush,
    input  logic       fwd_rs,
    input  logic       fwd_rt,
    input  word_t      mem_fwd_data,
    input  reg_write_t wr,
    input  reg_addr_t  dbg_addr,
    output word_t      dec_instr,
    output id_ex_t     id_ex,
    output logic       branch_taken,
    output pc_t        branch_target,
    output word_t      dbg_data
);
    logic [5:0] opcode;
    logic [5:0] funct;
    word_t      imm;
    word_t      rs_rf;
    word_t      rt_rf;
    word_t      rs_val;
    word_t      rt_val;
    ctrl_t      ctrl;
    logic       illegal;
    id_ex_t     next_item;

    assign dec_instr = if_valid ? if_instr : '0; // a bubble names only register zero
    assign opcode    = dec_instr[31:26];
    assign funct     = dec_instr[5:0];
    assign imm       = {{16{dec_instr[15]}}, dec_instr[15:0]};

    always_comb
    begin
        ctrl    = '0;
        illegal = 1'b0;
        case (opcode)
            OP_RTYPE:
            begin
                ctrl.reg_write = 1'b1;
                case (funct)
                    FN_ADD:  ctrl.alu_op = ALU_ADD;
                    FN_SUB:  ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    default: illegal = 1'b1;
                endcase
            end
            OP_ADDI:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_LW:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_SW:
            begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_BEQ:  ctrl.branch_eq = 1'b1;
            OP_BNE:  ctrl.branch_ne = 1'b1;
            default: illegal = 1'b1;
        endcase
        if (illegal)
            ctrl = '0;
    end

    reg_file reg_file_i (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .rs_addr   (dec_instr[25:21]),
        .rt_addr   (dec_instr[20:16]),
        .wr        (wr),
        .dbg_addr  (dbg_addr),
        .rs_val    (rs_rf),
        .rt_val    (rt_rf),
        .dbg_data  (dbg_data)
    );

    assign rs_val = fwd_rs ? mem_fwd_data : rs_rf;
    assign rt_val = fwd_rt ? mem_fwd_data : rt_rf;

    assign branch_target = if_pc + 32'd4 + {imm[29:0], 2'b00};
    assign branch_taken  = if_valid && !stall && !flush
                        && ((ctrl.branch_eq && rs_val == rt_val)
                         || (ctrl.branch_ne && rs_val != rt_val));

    always_comb
    begin
        next_item        = '0;
        next_item.valid  = if_valid && !stall && !flush; // stall sends a bubble to execute
        next_item.pc     = if_pc;
        next_item.ctrl   = ctrl;
        next_item.rs_val = rs_val;
        next_item.rt_val = rt_val;
        next_item.imm    = imm;
        next_item.dest   = (opcode == OP_RTYPE) ? dec_instr[15:11] : dec_instr[20:16];
        next_item.cause  = illegal ? CAUSE_ILLEGAL : CAUSE_NONE;
        if (!next_item.valid)
            next_item = '0;
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            id_ex <= '0;
        else
            id_ex <= next_item;
    end

endmodule

//--- rtl/hazard_unit.sv
// stalls one cycle behind an alu producer and two behind a load; forwards from the memory stage
`timescale 1ns/10ps
module hazard_unit
    import mips_pkg::*;
(
    input  logic      SYS_clk,
    input  logic      SYS_reset,
    input  word_t     dec_instr,
    input  id_ex_t    ex_item,
    input  reg_addr_t mem_dest,
    input  logic      mem_reg_write,
    output logic      stall,
    output logic      fwd_rs,
    output logic      fwd_rt
);
    logic [5:0] opcode;
    reg_addr_t  rs;
    reg_addr_t  rt;
    logic       uses_rt;
    logic       ex_hit;
    logic [1:0] stall_cnt; // extra stall cycles still owed

    assign opcode = dec_instr[31:26];
    assign rs     = dec_instr[25:21];
    assign rt     = dec_instr[20:16];

    // addi and lw take rt as destination, not as a source
    assign uses_rt = (opcode == OP_RTYPE) || (opcode == OP_SW)
                  || (opcode == OP_BEQ) || (opcode == OP_BNE);

    assign ex_hit = ex_item.valid && ex_item.ctrl.reg_write && (ex_item.dest != 5'd0)
                 && ((ex_item.dest == rs) || (uses_rt && ex_item.dest == rt));

    assign stall = ex_hit || (stall_cnt != 2'd0);

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            stall_cnt <= 2'd0;
        else if (stall_cnt != 2'd0)
            stall_cnt <= stall_cnt - 2'd1;
        else if (ex_hit && ex_item.ctrl.mem_read)
            stall_cnt <= 2'd1; // load needs a second cycle
    end

    assign fwd_rs = mem_reg_write && (mem_dest != 5'd0) && (mem_dest == rs);
    assign fwd_rt = mem_reg_write && (mem_dest != 5'd0) && (mem_dest == rt);

endmodule

//--- rtl/fetch_stage.sv
// program words load only while load is high; fetch reads the instruction memory combinationally
`timescale 1ns/10ps
module fetch_stage
    import mips_pkg::*;
(
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  logic               load,
    input  logic               prog_we,
    input  logic [IMEM_AW-1:0] prog_addr,
    input  word_t              prog_data,
    input  logic               stall,
    input  logic               branch_taken,
    input  pc_t                branch_target,
    input  logic               flush,
    output word_t              if_instr,
    output pc_t                if_pc,
    output logic               if_valid
);
    word_t imem [IMEM_DEPTH];
    pc_t   pc;
    word_t fetch_word;

    assign fetch_word = imem[pc[IMEM_AW+1:2]]; // word index of the byte pc

    always_ff @(posedge SYS_clk)
    begin
        if (prog_we && load)
            imem[prog_addr] <= prog_data;
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            pc <= RESET_PC;
        else if (load)
            pc <= RESET_PC;
        else if (!flush && !stall)
            pc <= branch_taken ? branch_target : pc + 32'd4;
    end

    // a taken branch kills the word fetched behind it
    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            if_valid <= 1'b0;
        else if (load || flush || branch_taken)
            if_valid <= 1'b0;
        else if (!stall)
            if_valid <= 1'b1;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (!stall)
        begin
            if_instr <= fetch_word;
            if_pc    <= pc;
        end
    end

    prog_we_needs_load : assert property (
        @(posedge SYS_clk) disable iff (SYS_reset) prog_we |-> load);

endmodule

//--- rtl/reg_file.sv
// register zero is hardwired to 0; a same-cycle write is visible on every read port
`timescale 1ns/10ps
module reg_file
    import mips_pkg::*;
(
    input  logic       SYS_clk,
    input  logic       SYS_reset,
    input  reg_addr_t  rs_addr,
    input  reg_addr_t  rt_addr,
    input  reg_write_t wr,
    input  reg_addr_t  dbg_addr,
    output word_t      rs_val,
    output word_t      rt_val,
    output word_t      dbg_data
);
    word_t regs [32];

    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == 5'd0)
            return '0;
        else if (wr.en && wr.addr == addr)
            return wr.data; // write-through
        else
            return regs[addr];
    endfunction

    always_comb
    begin
        rs_val   = read_port(rs_addr);
        rt_val   = read_port(rt_addr);
        dbg_data = read_port(dbg_addr);
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wr.en && wr.addr != 5'd0)
            regs[wr.addr] <= wr.data;
    end

endmodule

//--- rtl/mips_pkg.sv
// shared types for the core; memories are word indexed and wrap past their depth
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] pc_t;
    typedef logic [2:0]  exc_cause_t;
    typedef logic [2:0]  alu_op_t;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2B;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;

    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2A;

    localparam exc_cause_t CAUSE_NONE       = 3'd0;
    localparam exc_cause_t CAUSE_ILLEGAL    = 3'd1; // raised in decode
    localparam exc_cause_t CAUSE_OVERFLOW   = 3'd2; // raised in execute
    localparam exc_cause_t CAUSE_MISALIGN   = 3'd3; // raised in memory
    localparam exc_cause_t CAUSE_ZERO_WRITE = 3'd7; // raised in writeback

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_SLT = 3'd4;

    localparam int  IMEM_DEPTH = 64;
    localparam int  DMEM_DEPTH = 64;
    localparam int  IMEM_AW    = $clog2(IMEM_DEPTH);
    localparam int  DMEM_AW    = $clog2(DMEM_DEPTH);
    localparam pc_t RESET_PC   = 32'h0000_0000;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    alu_src_imm;
        logic    branch_eq;
        logic    branch_ne;
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        logic       valid;
        pc_t        pc;
        ctrl_t      ctrl;
        word_t      rs_val;
        word_t      rt_val;
        word_t      imm;
        reg_addr_t  dest;
        exc_cause_t cause;
    } id_ex_t;

    typedef struct packed {
        logic       valid;
        pc_t        pc;
        ctrl_t      ctrl;
        word_t      alu_result;
        word_t      store_data;
        reg_addr_t  dest;
        exc_cause_t cause;
    } ex_mem_t;

    typedef struct packed {
        logic       valid;
        pc_t        pc;
        ctrl_t      ctrl;
        word_t      alu_result;
        word_t      read_data;
        reg_addr_t  dest;
        exc_cause_t cause;
    } mem_wb_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } reg_write_t;

endpackage
